//--- src.f
src/vp8_coeff_pkg.sv
src/vp8_mem_pkg.sv
src/coeff_bus_if.sv
src/coeff_ram.sv
src/coeff_arbiter.sv
src/iwht_core.sv
src/wht_dc_engine.sv
src/vp8_dc_restore_top.sv
testbench/tb_clk_gen.sv
testbench/tb_vp8_dc_restore.sv

//--- Makefile
BIN  := obj_dir/Vtb_vp8_dc_restore
SRCS := $(wildcard src/*.sv testbench/*.sv)

.PHONY: all run clean

all: run

$(BIN): src.f $(SRCS)
	verilator --binary --timing --assert -Wno-fatal -f src.f --top-module tb_vp8_dc_restore

run: $(BIN)
	-./$(BIN) > sim.log 2>&1
	cat sim.log
	@if grep -q "FAIL: see errors above" sim.log; then echo "Simulation failed"; exit 1; fi
	@grep -q "PASS: all tests" sim.log || { echo "Simulation did not finish"; exit 1; }

clean:
	rm -rf obj_dir sim.log

//--- testbench/tb_vp8_dc_restore.sv
// Testbench for the luma DC restoration top level
// Y2 stimulus table with expected block 0 DC values
// Reference inverse WHT model, host bus tasks, check tasks

`timescale 1ns/1ps

module tb_vp8_dc_restore import vp8_coeff_pkg::*, vp8_mem_pkg::*; ();

    logic        clk;
    logic        rst_n;
    logic        start_i;
    logic        busy_o;
    logic        done_o;
    logic        host_req_i;
    logic        host_we_i;
    coeff_addr_t host_addr_i;
    coeff_t      host_wdata_i;
    logic        host_gnt_o;
    coeff_t      host_rdata_o;
    logic        host_rvalid_o;

    coeff_t shadow [MEM_DEPTH];
    coeff_t expect_dc [BLK_COEFFS];
    coeff_t rd_val;
    int     done_count = 0;

    // Zeros, DC only, AC impulse, alternating sign, max, min
    coeff_t y2_table [6][BLK_COEFFS] = '{
        '{default: 16'sd0},
        '{0: 16'sd800, default: 16'sd0},
        '{1: 16'sd160, default: 16'sd0},
        '{16'sd1000, -16'sd600, 16'sd1000, -16'sd600, 16'sd1000, -16'sd600, 16'sd1000, -16'sd600,
          16'sd1000, -16'sd600, 16'sd1000, -16'sd600, 16'sd1000, -16'sd600, 16'sd1000, -16'sd600},
        '{default: 16'sh7fff},
        '{default: 16'sh8000}
    };
    // DC of luma block 0 worked out by hand for each row
    coeff_t dc0_table [6] = '{16'sd0, 16'sd100, 16'sd20, 16'sd400, -16'sd2, 16'sd0};

    tb_clk_gen u_clk (.clk(clk));

    vp8_dc_restore_top dut (.*);

    // Done pulses, counted where done_o is stable
    always @(negedge clk) begin
        if (done_o) done_count <= done_count + 1;
    end

    // ----------------------------------------
    // Checks
    // ----------------------------------------
    task automatic check_coeff(input coeff_t got, input coeff_t exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s, got %0d expected %0d", $time, what, got, exp);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    task automatic check_flag(input logic got, input logic exp, input string what);
        if (got !== exp) begin
            $display("Mismatch at %0t ns: %s, got %b expected %b", $time, what, got, exp);
            $display("FAIL: see errors above");
            $fatal(1);
        end
    endtask

    task automatic report_timeout(input string what);
        $display("Timeout at %0t ns while waiting for %s", $time, what);
        $display("FAIL: see errors above");
        $fatal(1);
    endtask

    // Column pass, then row pass with rounding on the outer terms
    task automatic compute_expected(input int row);
        int col [BLK_COEFFS];
        int a0, a1, a2, a3;
        int b0, b1, b2, b3;
        for (int c = 0; c < 4; c++) begin
            a0 = y2_table[row][c] + y2_table[row][12 + c];
            a1 = y2_table[row][4 + c] + y2_table[row][8 + c];
            a2 = y2_table[row][4 + c] - y2_table[row][8 + c];
            a3 = y2_table[row][c] - y2_table[row][12 + c];
            col[c] = a0 + a1;
            col[4 + c] = a3 + a2;
            col[8 + c] = a0 - a1;
            col[12 + c] = a3 - a2;
        end
        for (int r = 0; r < 4; r++) begin
            b0 = col[4 * r] + col[4 * r + 3] + WHT_ROUND;
            b1 = col[4 * r + 1] + col[4 * r + 2];
            b2 = col[4 * r + 1] - col[4 * r + 2];
            b3 = col[4 * r] - col[4 * r + 3] + WHT_ROUND;
            expect_dc[4 * r] = coeff_t'((b0 + b1) >>> WHT_SHIFT);
            expect_dc[4 * r + 1] = coeff_t'((b3 + b2) >>> WHT_SHIFT);
            expect_dc[4 * r + 2] = coeff_t'((b0 - b1) >>> WHT_SHIFT);
            expect_dc[4 * r + 3] = coeff_t'((b3 - b2) >>> WHT_SHIFT);
        end
    endtask

    // ----------------------------------------
    // Host bus and start strobe
    // ----------------------------------------
    task automatic host_access(input logic we, input coeff_addr_t addr, input coeff_t wdata);
        int n;
        @(posedge clk);
        host_req_i   <= 1'b1;
        host_we_i    <= we;
        host_addr_i  <= addr;
        host_wdata_i <= wdata;
        n = 0;
        do begin
            @(negedge clk);
            n++;
            if (n > 200) report_timeout("host grant");
        end while (!host_gnt_o);
        // This edge performs the access
        @(posedge clk);
        host_req_i <= 1'b0;
        if (!we) begin
            // Read data is due one cycle after the grant
            n = 0;
            do begin
                @(negedge clk);
                n++;
                if (n > 1) report_timeout("host read data");
            end while (!host_rvalid_o);
            rd_val = host_rdata_o;
        end
    endtask

    task automatic host_write(input coeff_addr_t addr, input coeff_t data);
        host_access(1'b1, addr, data);
        shadow[addr] = data;
    endtask

    task automatic read_check(input coeff_addr_t addr, input string what);
        host_access(1'b0, addr, '0);
        check_coeff(rd_val, shadow[addr], $sformatf("%s at word %0d", what, addr));
    endtask

    task automatic pulse_start();
        @(posedge clk);
        start_i <= 1'b1;
        @(posedge clk);
        start_i <= 1'b0;
    endtask

    task automatic wait_done(input int target);
        int n;
        n = 0;
        while (done_count < target) begin
            @(posedge clk);
            n++;
            if (n > 1000) report_timeout("done_o");
        end
    endtask

    initial begin
        coeff_addr_t ac_addr;
        void'($urandom(32'h8d6d));
        rst_n        = 1'b0;
        start_i      = 1'b0;
        host_req_i   = 1'b0;
        host_we_i    = 1'b0;
        host_addr_i  = '0;
        host_wdata_i = '0;
        repeat (16) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_flag(done_o, 1'b0, "done_o after reset");
        check_flag(busy_o, 1'b0, "busy_o after reset");
        check_flag(host_gnt_o, 1'b0, "host_gnt_o after reset");
        check_flag(host_rvalid_o, 1'b0, "host_rvalid_o after reset");

        for (int row = 0; row < 6; row++) begin
            compute_expected(row);
            for (int a = 0; a < 256; a++) begin
                host_write(coeff_addr_t'(a), coeff_t'($urandom()));
            end
            for (int k = 0; k < BLK_COEFFS; k++) begin
                host_write(Y2_BASE + coeff_addr_t'(k), y2_table[row][k]);
            end
            pulse_start();
            // Host traffic contends with the running engine
            read_check(Y2_BASE + coeff_addr_t'(row), "Y2 read during run");
            check_flag(busy_o, 1'b1, "busy_o during run");
            pulse_start();
            ac_addr = coeff_addr_t'({4'($urandom_range(15, 0)), 4'($urandom_range(15, 1))});
            host_write(ac_addr, coeff_t'($urandom()));
            read_check(ac_addr, "AC word written during run");
            wait_done(row + 1);
            // A second run would finish well inside this window
            repeat (60) @(posedge clk);
            @(negedge clk);
            check_flag(done_count == row + 1, 1'b1, "one done_o pulse per run");
            check_flag(busy_o, 1'b0, "busy_o after run");
            for (int k = 0; k < BLK_COEFFS; k++) begin
                shadow[16 * k] = expect_dc[k];
            end
            for (int a = 0; a < 272; a++) begin
                read_check(coeff_addr_t'(a), "readback");
            end
            host_access(1'b0, LUMA_BASE, '0);
            check_coeff(rd_val, dc0_table[row], "block 0 DC against table");
        end

        $display("PASS: all tests");
        $finish;
    end

endmodule

//--- testbench/tb_clk_gen.sv
// Testbench clock source, 100 ns period

`timescale 1ns/1ps

module tb_clk_gen (
    output logic clk
);

    initial begin
        clk = 1'b0;
        forever #50 clk = ~clk;
    end

endmodule

//--- src/vp8_dc_restore_top.sv
// Luma DC restoration top level
// Host port and DC engine share the coefficient RAM
// through the round-robin arbiter

`timescale 1ns/1ps

module vp8_dc_restore_top import vp8_coeff_pkg::*, vp8_mem_pkg::*; (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        start_i,
    output logic        busy_o,
    output logic        done_o,
    input  logic        host_req_i,
    input  logic        host_we_i,
    input  coeff_addr_t host_addr_i,
    input  coeff_t      host_wdata_i,
    output logic        host_gnt_o,
    output coeff_t      host_rdata_o,
    output logic        host_rvalid_o
);

    coeff_bus_if host_bus ();
    coeff_bus_if eng_bus ();
    coeff_bus_if mem_bus ();

    // Host side of the bus
    assign host_bus.req   = host_req_i;
    assign host_bus.we    = host_we_i;
    assign host_bus.addr  = host_addr_i;
    assign host_bus.wdata = host_wdata_i;
    assign host_gnt_o     = host_bus.gnt;
    assign host_rdata_o   = host_bus.rdata;
    assign host_rvalid_o  = host_bus.rvalid;

    coeff_arbiter u_arb (
        .clk      (clk),
        .rst_n    (rst_n),
        .host_bus (host_bus.arbiter),
        .eng_bus  (eng_bus.arbiter),
        .mem_bus  (mem_bus.requester)
    );

    coeff_ram u_ram (
        .clk     (clk),
        .mem_bus (mem_bus.memory)
    );

    wht_dc_engine u_eng (
        .clk     (clk),
        .rst_n   (rst_n),
        .start_i (start_i),
        .busy_o  (busy_o),
        .done_o  (done_o),
        .bus     (eng_bus.requester)
    );

endmodule

//--- src/wht_dc_engine.sv
// DC restoration engine
// Gathers the Y2 block, runs the inverse WHT and
// scatters the results into the luma DC words

`timescale 1ns/1ps

module wht_dc_engine import vp8_coeff_pkg::*, vp8_mem_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    input  logic  start_i,
    output logic  busy_o,
    output logic  done_o,
    coeff_bus_if.requester bus
);

    typedef enum logic [2:0] {IDLE, READ, XFORM, WRITE, FINISH} eng_state_e;

    eng_state_e state;
    coeff_idx_t idx;
    coeff_idx_t cap_idx;
    logic       rd_all;
    logic       core_start;
    logic       core_done;
    coeff_t     gather   [BLK_COEFFS];
    coeff_t     core_out [BLK_COEFFS];

    iwht_core u_iwht (
        .clk      (clk),
        .rst_n    (rst_n),
        .start_i  (core_start),
        .coeffs_i (gather),
        .coeffs_o (core_out),
        .done_o   (core_done)
    );

    // ----------------------------------------
    // Bus command, idx only moves on a grant
    // ----------------------------------------
    assign bus.req   = (state == READ && !rd_all) || state == WRITE;
    assign bus.we    = (state == WRITE);
    assign bus.addr  = (state == WRITE) ? LUMA_BASE + coeff_addr_t'({idx, 4'h0})
                                        : Y2_BASE + coeff_addr_t'(idx);
    assign bus.wdata = core_out[idx];

    assign core_start = (state == XFORM);
    assign busy_o     = (state != IDLE);
    assign done_o     = (state == FINISH);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= IDLE;
            idx     <= '0;
            cap_idx <= '0;
            rd_all  <= 1'b0;
        end else begin
            unique case (state)
                IDLE: begin
                    if (start_i) begin
                        state   <= READ;
                        idx     <= '0;
                        cap_idx <= '0;
                        rd_all  <= 1'b0;
                    end
                end
                READ: begin
                    if (bus.req && bus.gnt) begin
                        idx <= idx + 1'b1;
                        if (idx == coeff_idx_t'(BLK_COEFFS - 1)) rd_all <= 1'b1;
                    end
                    // Leave once the last read word is in
                    if (bus.rvalid) begin
                        cap_idx <= cap_idx + 1'b1;
                        if (cap_idx == coeff_idx_t'(BLK_COEFFS - 1)) state <= XFORM;
                    end
                end
                XFORM: begin
                    idx   <= '0;
                    state <= WRITE;
                end
                WRITE: begin
                    if (bus.gnt) begin
                        idx <= idx + 1'b1;
                        if (idx == coeff_idx_t'(BLK_COEFFS - 1)) state <= FINISH;
                    end
                end
                default: state <= IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (state == READ && bus.rvalid) begin
            gather[cap_idx] <= bus.rdata;
        end
    end

    a_req_busy: assert property (@(posedge clk) disable iff (!rst_n)
        bus.req |-> busy_o);

    // Core results arrive just as the write phase opens
    a_core_write: assert property (@(posedge clk) disable iff (!rst_n)
        core_done |-> (state == WRITE && idx == '0));

endmodule

//--- src/iwht_core.sv
// 4x4 inverse Walsh-Hadamard transform
// Column pass, row pass with rounding, arithmetic shift
// Results registered one cycle after start

`timescale 1ns/1ps

module iwht_core import vp8_coeff_pkg::*; (
    input  logic   clk,
    input  logic   rst_n,
    input  logic   start_i,
    input  coeff_t coeffs_i [BLK_COEFFS],
    output coeff_t coeffs_o [BLK_COEFFS],
    output logic   done_o
);

    logic signed [17:0] col [BLK_COEFFS];
    logic signed [20:0] res [BLK_COEFFS];

    // ----------------------------------------
    // First pass, one butterfly per column
    // ----------------------------------------
    for (genvar c = 0; c < 4; c++) begin : g_col
        logic signed [16:0] a0, a1, a2, a3;

        assign a0 = coeffs_i[c] + coeffs_i[12 + c];
        assign a1 = coeffs_i[4 + c] + coeffs_i[8 + c];
        assign a2 = coeffs_i[4 + c] - coeffs_i[8 + c];
        assign a3 = coeffs_i[c] - coeffs_i[12 + c];

        assign col[c]      = a0 + a1;
        assign col[4 + c]  = a3 + a2;
        assign col[8 + c]  = a0 - a1;
        assign col[12 + c] = a3 - a2;
    end

    // ----------------------------------------
    // Second pass, one butterfly per row
    // ----------------------------------------
    for (genvar r = 0; r < 4; r++) begin : g_row
        logic signed [19:0] b0, b1, b2, b3;

        // Rounding enters through the outer terms
        assign b0 = col[4 * r] + col[4 * r + 3] + 20'(WHT_ROUND);
        assign b1 = col[4 * r + 1] + col[4 * r + 2];
        assign b2 = col[4 * r + 1] - col[4 * r + 2];
        assign b3 = col[4 * r] - col[4 * r + 3] + 20'(WHT_ROUND);

        assign res[4 * r]     = b0 + b1;
        assign res[4 * r + 1] = b3 + b2;
        assign res[4 * r + 2] = b0 - b1;
        assign res[4 * r + 3] = b3 - b2;
    end

    // Shift and truncate, held until the next start
    always_ff @(posedge clk) begin
        if (start_i) begin
            for (int k = 0; k < BLK_COEFFS; k++) begin
                coeffs_o[k] <= coeff_t'(res[k] >>> WHT_SHIFT);
            end
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            done_o <= 1'b0;
        end else begin
            done_o <= start_i;
        end
    end

endmodule

//--- src/coeff_arbiter.sv
// Two-way round-robin arbiter for the coefficient memory
// Host and DC engine share one single-port RAM
// Read data returns to the requester that issued the read

`timescale 1ns/1ps

module coeff_arbiter (
    input  logic           clk,
    input  logic           rst_n,
    coeff_bus_if.arbiter   host_bus,
    coeff_bus_if.arbiter   eng_bus,
    coeff_bus_if.requester mem_bus
);

    logic last_eng;
    logic host_gnt;
    logic eng_gnt;
    logic rd_host;
    logic rd_eng;

    // Last winner loses a tie, lone request wins at once
    assign host_gnt = host_bus.req && (!eng_bus.req || last_eng);
    assign eng_gnt  = eng_bus.req && (!host_bus.req || !last_eng);

    assign host_bus.gnt = host_gnt;
    assign eng_bus.gnt  = eng_gnt;

    // ----------------------------------------
    // Winner's command onto the RAM
    // ----------------------------------------
    assign mem_bus.req   = host_gnt || eng_gnt;
    assign mem_bus.we    = eng_gnt ? eng_bus.we    : host_bus.we;
    assign mem_bus.addr  = eng_gnt ? eng_bus.addr  : host_bus.addr;
    assign mem_bus.wdata = eng_gnt ? eng_bus.wdata : host_bus.wdata;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            last_eng <= 1'b0;
            rd_host  <= 1'b0;
            rd_eng   <= 1'b0;
        end else begin
            if (eng_gnt) begin
                last_eng <= 1'b1;
            end else if (host_gnt) begin
                last_eng <= 1'b0;
            end
            // Owner of the read in flight
            rd_host <= host_gnt && !host_bus.we;
            rd_eng  <= eng_gnt && !eng_bus.we;
        end
    end

    assign host_bus.rvalid = rd_host;
    assign eng_bus.rvalid  = rd_eng;
    assign host_bus.rdata  = rd_host ? mem_bus.rdata : '0;
    assign eng_bus.rdata   = rd_eng ? mem_bus.rdata : '0;

    a_one_gnt: assert property (@(posedge clk) disable iff (!rst_n)
        !(host_bus.gnt && eng_bus.gnt));

    // Granted read reached the RAM at the requester's address
    a_host_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
        host_bus.rvalid |->
            $past(host_bus.gnt && !mem_bus.we && mem_bus.addr == host_bus.addr));

    a_eng_rvalid: assert property (@(posedge clk) disable iff (!rst_n)
        eng_bus.rvalid |->
            $past(eng_bus.gnt && !mem_bus.we && mem_bus.addr == eng_bus.addr));

endmodule

//--- src/coeff_ram.sv
// Single-port coefficient memory
// Synchronous write, registered read, no content reset

`timescale 1ns/1ps

module coeff_ram import vp8_coeff_pkg::*, vp8_mem_pkg::*; (
    input  logic    clk,
    coeff_bus_if.memory mem_bus
);

    coeff_t mem [MEM_DEPTH];

    logic        en_i;
    logic        we_i;
    coeff_addr_t addr_i;
    coeff_t      wdata_i;
    coeff_t      rdata_o;

    assign en_i    = mem_bus.req;
    assign we_i    = mem_bus.we;
    assign addr_i  = mem_bus.addr;
    assign wdata_i = mem_bus.wdata;

    // Read data lands one cycle after the enabled edge
    always_ff @(posedge clk) begin
        if (en_i) begin
            if (we_i) begin
                mem[addr_i] <= wdata_i;
            end else begin
                rdata_o <= mem[addr_i];
            end
        end
    end

    assign mem_bus.rdata = rdata_o;

endmodule

//--- src/coeff_bus_if.sv
// Request/grant bus to the coefficient memory
// Modports for requesters, the arbiter inputs and the RAM

`timescale 1ns/1ps

interface coeff_bus_if import vp8_coeff_pkg::*, vp8_mem_pkg::*; ();

    logic        req;
    logic        gnt;
    logic        we;
    coeff_addr_t addr;
    coeff_t      wdata;
    coeff_t      rdata;
    logic        rvalid;

    // Command held until gnt is seen at a rising edge
    modport requester (output req, we, addr, wdata, input gnt, rdata, rvalid);

    modport arbiter (input req, we, addr, wdata, output gnt, rdata, rvalid);

    // RAM side, req acts as the enable
    modport memory (input req, we, addr, wdata, output rdata);

endinterface

//--- src/vp8_mem_pkg.sv
// Coefficient memory geometry and address type
// Base addresses of the luma blocks and the Y2 block

package vp8_mem_pkg;

    // Word address into the coefficient memory
    typedef logic [8:0] coeff_addr_t;

    localparam int MEM_DEPTH = 512;

    // Y2 block, 16 words at 256..271
    localparam coeff_addr_t Y2_BASE = 9'd256;

    // Luma block b at 16*b, DC word first
    localparam coeff_addr_t LUMA_BASE = 9'd0;

endpackage

//--- src/vp8_coeff_pkg.sv
// Coefficient types for the luma DC restoration stage
// Inverse WHT rounding and shift constants
// Block geometry shared by the core and the engine

package vp8_coeff_pkg;

    // ----------------------------------------
    // Coefficient types
    // ----------------------------------------

    // One dequantized or reconstructed coefficient
    typedef logic signed [15:0] coeff_t;

    // Raster position inside a 4x4 block
    typedef logic [3:0] coeff_idx_t;

    // ----------------------------------------
    // Transform constants
    // ----------------------------------------

    localparam int WHT_ROUND  = 3;
    localparam int WHT_SHIFT  = 3;
    localparam int BLK_COEFFS = 16;

endpackage
